// ==== logic/videoPkg.sv ====
`default_nettype none

package videoPkg;

    // ##################################################
    // raster geometry
    // ##################################################
    localparam int pixelW = 11;

    typedef logic [pixelW-1:0] pixelT;
    typedef logic [7:0] rgbT; // 3-3-2 format with red in the top bits.

    localparam pixelT hVisible = 11'd80;
    localparam pixelT hTotal = 11'd96;
    localparam pixelT vVisible = 11'd50;
    localparam pixelT vTotal = 11'd56;

    localparam pixelT hSyncStart = 11'd84; // sync is low from start up to end minus one.
    localparam pixelT hSyncEnd = 11'd90;
    localparam pixelT vSyncStart = 11'd51;
    localparam pixelT vSyncEnd = 11'd53;

    localparam rgbT backgroundRgb = 8'h02;

    typedef struct packed {
        rgbT rgb;
        logic hSync;
        logic vSync;
    } vgaT;

endpackage

`default_nettype wire

// ==== logic/gamePkg.sv ====
`default_nettype none

package gamePkg;

    typedef enum logic [2:0] {
        stIdle,
        stPlay,
        stPause,
        stWon,
        stLost
    } gameStateT;

    // ##################################################
    // invader row
    // ##################################################
    localparam int numInvaders = 4;
    localparam int invaderIdxW = $clog2(numInvaders);
    localparam videoPkg::pixelT invaderW = 11'd6;
    localparam videoPkg::pixelT invaderH = 11'd4;
    localparam videoPkg::pixelT invaderGap = 11'd4;
    localparam videoPkg::pixelT invaderPitch = invaderW + invaderGap;
    localparam videoPkg::pixelT rowW = 11'd4 * invaderW + 11'd3 * invaderGap;
    localparam videoPkg::pixelT invaderStartX = 11'd2;
    localparam videoPkg::pixelT invaderStartY = 11'd8;
    localparam videoPkg::pixelT invaderDropY = 11'd4;

    // ##################################################
    // ship and missile
    // ##################################################
    localparam videoPkg::pixelT shipW = 11'd8;
    localparam videoPkg::pixelT shipH = 11'd3;
    localparam videoPkg::pixelT shipY = 11'd46;
    localparam videoPkg::pixelT shipStartX = 11'd36;
    localparam videoPkg::pixelT missileH = 11'd3;
    localparam videoPkg::pixelT missileStep = 11'd2;
    localparam videoPkg::pixelT lossRow = shipY; // the game is lost once the invaders touch the ship row.

    localparam videoPkg::rgbT shipRgb = 8'h1C;
    localparam videoPkg::rgbT missileRgb = 8'hFC;
    localparam videoPkg::rgbT invaderRgb = 8'hE0;

    // ##################################################
    // score
    // ##################################################
    typedef logic [3:0] digitT;
    typedef logic [6:0] segT; // active low with segment a in bit 0.

    localparam int killPoints = 10;
    localparam digitT killOnes = digitT'(killPoints % 10);
    localparam digitT killTens = digitT'((killPoints / 10) % 10);
    localparam digitT killHundreds = digitT'((killPoints / 100) % 10);

    typedef struct packed {
        logic missileInvader;
        logic shipInvader;
    } hitT;

endpackage

`default_nettype wire

// ==== logic/pixelScanner.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixelScanner (
    input logic clk,
    input logic rstN,
    output videoPkg::pixelT pixelX,
    output videoPkg::pixelT pixelY,
    output logic hSync,
    output logic vSync,
    output logic visible,
    output logic startOfFrame
);
    import videoPkg::*;

    logic lastX;
    logic lastY;

    assign lastX = pixelX == hTotal - 11'd1;
    assign lastY = pixelY == vTotal - 11'd1;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pixelX <= '0;
            pixelY <= '0;
            startOfFrame <= 1'b0;
        end else begin
            startOfFrame <= lastX && lastY; // high together with the wrap to the origin.
            if (lastX) begin
                pixelX <= '0;
                pixelY <= lastY ? '0 : pixelY + 11'd1;
            end else begin
                pixelX <= pixelX + 11'd1;
            end
        end
    end

    assign hSync = !(pixelX >= hSyncStart && pixelX < hSyncEnd);
    assign vSync = !(pixelY >= vSyncStart && pixelY < vSyncEnd);
    assign visible = pixelX < hVisible && pixelY < vVisible;

    assert property (@(posedge clk) disable iff (!rstN) pixelX < hTotal && pixelY < vTotal)
        else $error("pixel counters ran past the raster totals.");

endmodule

`default_nettype wire

// ==== logic/gameController.sv ====
`timescale 1ns/1ns
`default_nettype none

module gameController (
    input logic clk,
    input logic rstN,
    input logic startGame,
    input logic pause,
    input logic allDead,
    input logic reachedBottom,
    input logic shipHit,
    output logic playEnable,
    output logic objectReset,
    output logic gameWon,
    output logic gameOver
);
    import gamePkg::*;

    gameStateT state;
    gameStateT stateNext;
    logic restart;

    assign restart = startGame && (state == stIdle || state == stWon || state == stLost);

    always_comb begin
        stateNext = state;
        case (state)
            stIdle, stWon, stLost: begin
                if (restart) begin
                    stateNext = stPlay;
                end
            end
            stPlay: begin
                if (!objectReset) begin // the objects still show the old game in this cycle.
                    if (allDead) begin
                        stateNext = stWon;
                    end else if (reachedBottom || shipHit) begin
                        stateNext = stLost;
                    end else if (pause) begin
                        stateNext = stPause;
                    end
                end
            end
            stPause: begin
                if (!pause) begin
                    stateNext = stPlay;
                end
            end
            default: stateNext = stIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stIdle;
            objectReset <= 1'b0;
        end else begin
            state <= stateNext;
            objectReset <= restart;
        end
    end

    assign playEnable = state == stPlay;
    assign gameWon = state == stWon;
    assign gameOver = state == stLost;

    assert property (@(posedge clk) disable iff (!rstN) !(gameWon && gameOver))
        else $error("gameWon and gameOver are high together.");

endmodule

`default_nettype wire

// ==== logic/playerShip.sv ====
`timescale 1ns/1ns
`default_nettype none

module playerShip (
    input logic clk,
    input logic rstN,
    input logic objectReset,
    input logic playEnable,
    input logic moveLeft,
    input logic moveRight,
    input logic fire,
    input logic startOfFrame,
    input videoPkg::pixelT pixelX,
    input videoPkg::pixelT pixelY,
    input gamePkg::hitT hitPulse,
    output logic shipDr,
    output logic missileDr,
    output videoPkg::rgbT shipRgbOut,
    output videoPkg::rgbT missileRgbOut
);
    import videoPkg::*;
    import gamePkg::*;

    pixelT shipX;
    pixelT missileX;
    pixelT missileY;
    logic missileActive;
    logic step;

    assign step = startOfFrame && playEnable;

    // ##################################################
    // movement
    // ##################################################
    always_ff @(posedge clk) begin
        if (!rstN || objectReset) begin
            shipX <= shipStartX;
            missileActive <= 1'b0;
        end else begin
            if (step) begin
                if (moveLeft && !moveRight && shipX != '0) begin
                    shipX <= shipX - 11'd1;
                end else if (moveRight && !moveLeft && shipX < hVisible - shipW) begin
                    shipX <= shipX + 11'd1;
                end
                if (missileActive) begin
                    missileActive <= missileY >= missileStep; // gone once it leaves the top.
                end else if (fire) begin
                    missileActive <= 1'b1;
                end
            end
            if (playEnable && hitPulse.missileInvader) begin
                missileActive <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step && missileActive) begin
            missileY <= missileY - missileStep;
        end else if (step && fire) begin
            missileX <= shipX + shipW / 11'd2; // launched from the ship centre.
            missileY <= shipY - missileH;
        end
    end

    // ##################################################
    // draw requests
    // ##################################################
    always_ff @(posedge clk) begin
        if (!rstN) begin
            shipDr <= 1'b0;
            missileDr <= 1'b0;
        end else begin
            shipDr <= pixelX >= shipX && pixelX < shipX + shipW
                && pixelY >= shipY && pixelY < shipY + shipH;
            missileDr <= missileActive && pixelX == missileX
                && pixelY >= missileY && pixelY < missileY + missileH;
        end
    end

    assign shipRgbOut = shipRgb;
    assign missileRgbOut = missileRgb;

endmodule

`default_nettype wire

// ==== logic/invaderRow.sv ====
`timescale 1ns/1ns
`default_nettype none

module invaderRow (
    input logic clk,
    input logic rstN,
    input logic objectReset,
    input logic playEnable,
    input logic startOfFrame,
    input videoPkg::pixelT pixelX,
    input videoPkg::pixelT pixelY,
    input gamePkg::hitT hitPulse,
    output logic invaderDr,
    output videoPkg::rgbT invaderRgbOut,
    output logic killPulse,
    output logic allDead,
    output logic reachedBottom
);
    import videoPkg::*;
    import gamePkg::*;

    pixelT originX;
    pixelT originY;
    logic dirRight;
    logic [numInvaders-1:0] aliveMask;
    logic [invaderIdxW-1:0] pixIndex;
    logic [invaderIdxW-1:0] drIndex;
    logic [invaderIdxW-1:0] hitIndex;
    logic pixHit;
    logic inBand;
    pixelT leftEdge;

    // ##################################################
    // marching and kills
    // ##################################################
    always_ff @(posedge clk) begin
        if (!rstN || objectReset) begin
            originX <= invaderStartX;
            originY <= invaderStartY;
            dirRight <= 1'b1;
            aliveMask <= '1;
            killPulse <= 1'b0;
        end else begin
            killPulse <= 1'b0;
            if (startOfFrame && playEnable) begin
                if (dirRight ? originX + rowW >= hVisible : originX == '0) begin
                    dirRight <= !dirRight; // bounce off the wall and step down.
                    originY <= originY + invaderDropY;
                end else begin
                    originX <= dirRight ? originX + 11'd1 : originX - 11'd1;
                end
            end
            if (playEnable && hitPulse.missileInvader) begin
                aliveMask[hitIndex] <= 1'b0;
                killPulse <= 1'b1;
            end
        end
    end

    // ##################################################
    // drawing
    // ##################################################
    assign inBand = pixelY >= originY && pixelY < originY + invaderH;

    always_comb begin
        pixHit = 1'b0;
        pixIndex = '0;
        leftEdge = originX;
        for (int i = 0; i < numInvaders; i++) begin
            leftEdge = originX + pixelT'(i) * invaderPitch;
            if (aliveMask[i] && inBand && pixelX >= leftEdge && pixelX < leftEdge + invaderW) begin
                pixHit = 1'b1;
                pixIndex = invaderIdxW'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            invaderDr <= 1'b0;
        end else begin
            invaderDr <= pixHit;
        end
    end

    always_ff @(posedge clk) begin
        drIndex <= pixIndex;
        hitIndex <= drIndex; // lines up with the hit pulse one cycle after the draw request.
    end

    assign invaderRgbOut = invaderRgb;
    assign allDead = aliveMask == '0;
    assign reachedBottom = originY + invaderH > lossRow;

    assert property (@(posedge clk) disable iff (!rstN)
        killPulse |-> ($past(aliveMask) & ~aliveMask) != '0)
        else $error("killPulse for an invader that was already dead.");

endmodule

`default_nettype wire

// ==== logic/hitDetection.sv ====
`timescale 1ns/1ns
`default_nettype none

module hitDetection (
    input logic clk,
    input logic rstN,
    input logic startOfFrame,
    input logic shipDr,
    input logic missileDr,
    input logic invaderDr,
    output gamePkg::hitT hitPulse
);
    import gamePkg::*;

    hitT overlap;
    hitT seen;

    assign overlap.missileInvader = missileDr && invaderDr;
    assign overlap.shipInvader = shipDr && invaderDr;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            seen <= '0;
            hitPulse <= '0;
        end else begin
            hitPulse <= hitT'(overlap & ~seen); // only the first overlap of a pair in a frame.
            if (startOfFrame) begin
                seen <= '0;
            end else begin
                seen <= hitT'(seen | overlap);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/videoMixer.sv ====
`timescale 1ns/1ns
`default_nettype none

module videoMixer (
    input logic clk,
    input logic rstN,
    input logic hSync,
    input logic vSync,
    input logic visible,
    input logic shipDr,
    input logic missileDr,
    input logic invaderDr,
    input videoPkg::rgbT shipRgbIn,
    input videoPkg::rgbT missileRgbIn,
    input videoPkg::rgbT invaderRgbIn,
    output videoPkg::vgaT vga
);
    import videoPkg::*;

    logic hSyncQ;
    logic vSyncQ;
    logic visibleQ;
    rgbT pixelRgb;

    always_comb begin
        if (!visibleQ) begin
            pixelRgb = '0;
        end else if (missileDr) begin
            pixelRgb = missileRgbIn;
        end else if (shipDr) begin
            pixelRgb = shipRgbIn;
        end else if (invaderDr) begin
            pixelRgb = invaderRgbIn;
        end else begin
            pixelRgb = backgroundRgb;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            hSyncQ <= 1'b1;
            vSyncQ <= 1'b1;
            visibleQ <= 1'b0;
            vga <= '{rgb: '0, hSync: 1'b1, vSync: 1'b1};
        end else begin
            hSyncQ <= hSync; // first stage matches the draw request latency.
            vSyncQ <= vSync;
            visibleQ <= visible;
            vga <= '{rgb: pixelRgb, hSync: hSyncQ, vSync: vSyncQ};
        end
    end

endmodule

`default_nettype wire

// ==== logic/scoreCounter.sv ====
`timescale 1ns/1ns
`default_nettype none

module scoreCounter (
    input logic clk,
    input logic rstN,
    input logic objectReset,
    input logic killPulse,
    output gamePkg::segT hex0,
    output gamePkg::segT hex1,
    output gamePkg::segT hex2
);
    import gamePkg::*;

    digitT digit0;
    digitT digit1;
    digitT digit2;
    logic [4:0] sum0;
    logic [4:0] sum1;
    logic [4:0] sum2;

    function automatic logic [4:0] bcdAdd(input digitT a, input digitT b, input logic carryIn);
        logic [4:0] s;
        s = a + b + carryIn;
        if (s > 5'd9) begin
            s = s + 5'd6; // carry lands in bit 4.
        end
        return s;
    endfunction

    function automatic segT segOf(input digitT d);
        case (d)
            4'd0: return 7'b1000000;
            4'd1: return 7'b1111001;
            4'd2: return 7'b0100100;
            4'd3: return 7'b0110000;
            4'd4: return 7'b0011001;
            4'd5: return 7'b0010010;
            4'd6: return 7'b0000010;
            4'd7: return 7'b1111000;
            4'd8: return 7'b0000000;
            4'd9: return 7'b0010000;
            default: return 7'b1111111;
        endcase
    endfunction

    assign sum0 = bcdAdd(digit0, killOnes, 1'b0);
    assign sum1 = bcdAdd(digit1, killTens, sum0[4]);
    assign sum2 = bcdAdd(digit2, killHundreds, sum1[4]);

    always_ff @(posedge clk) begin
        if (!rstN || objectReset) begin
            digit0 <= '0;
            digit1 <= '0;
            digit2 <= '0;
        end else if (killPulse && !sum2[4]) begin // holds at 990 instead of wrapping.
            digit0 <= sum0[3:0];
            digit1 <= sum1[3:0];
            digit2 <= sum2[3:0];
        end
    end

    assign hex0 = segOf(digit0);
    assign hex1 = segOf(digit1);
    assign hex2 = segOf(digit2);

endmodule

`default_nettype wire

// ==== logic/invadersTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module invadersTop (
    input logic clk,
    input logic rstN,
    input logic startGame,
    input logic pause,
    input logic moveLeft,
    input logic moveRight,
    input logic fire,
    output videoPkg::vgaT vga,
    output gamePkg::segT hex0,
    output gamePkg::segT hex1,
    output gamePkg::segT hex2,
    output logic gameWon,
    output logic gameOver
);
    import videoPkg::*;
    import gamePkg::*;

    pixelT pixelX;
    pixelT pixelY;
    logic hSync;
    logic vSync;
    logic visible;
    logic startOfFrame;

    logic shipDr;
    logic missileDr;
    logic invaderDr;
    rgbT shipColor;
    rgbT missileColor;
    rgbT invaderColor;

    hitT hitPulse;
    logic killPulse;
    logic allDead;
    logic reachedBottom;
    logic playEnable;
    logic objectReset;

    // ##################################################
    // raster and control
    // ##################################################
    pixelScanner scannerInst (
        .clk            (clk),
        .rstN           (rstN),
        .pixelX         (pixelX),
        .pixelY         (pixelY),
        .hSync          (hSync),
        .vSync          (vSync),
        .visible        (visible),
        .startOfFrame   (startOfFrame));

    gameController controllerInst (
        .clk            (clk),
        .rstN           (rstN),
        .startGame      (startGame),
        .pause          (pause),
        .allDead        (allDead),
        .reachedBottom  (reachedBottom),
        .shipHit        (hitPulse.shipInvader),
        .playEnable     (playEnable),
        .objectReset    (objectReset),
        .gameWon        (gameWon),
        .gameOver       (gameOver));

    // ##################################################
    // objects
    // ##################################################
    playerShip shipInst (
        .clk            (clk),
        .rstN           (rstN),
        .objectReset    (objectReset),
        .playEnable     (playEnable),
        .moveLeft       (moveLeft),
        .moveRight      (moveRight),
        .fire           (fire),
        .startOfFrame   (startOfFrame),
        .pixelX         (pixelX),
        .pixelY         (pixelY),
        .hitPulse       (hitPulse),
        .shipDr         (shipDr),
        .missileDr      (missileDr),
        .shipRgbOut     (shipColor),
        .missileRgbOut  (missileColor));

    invaderRow invadersInst (
        .clk            (clk),
        .rstN           (rstN),
        .objectReset    (objectReset),
        .playEnable     (playEnable),
        .startOfFrame   (startOfFrame),
        .pixelX         (pixelX),
        .pixelY         (pixelY),
        .hitPulse       (hitPulse),
        .invaderDr      (invaderDr),
        .invaderRgbOut  (invaderColor),
        .killPulse      (killPulse),
        .allDead        (allDead),
        .reachedBottom  (reachedBottom));

    hitDetection hitInst (
        .clk            (clk),
        .rstN           (rstN),
        .startOfFrame   (startOfFrame),
        .shipDr         (shipDr),
        .missileDr      (missileDr),
        .invaderDr      (invaderDr),
        .hitPulse       (hitPulse));

    // ##################################################
    // outputs
    // ##################################################
    videoMixer mixerInst (
        .clk            (clk),
        .rstN           (rstN),
        .hSync          (hSync),
        .vSync          (vSync),
        .visible        (visible),
        .shipDr         (shipDr),
        .missileDr      (missileDr),
        .invaderDr      (invaderDr),
        .shipRgbIn      (shipColor),
        .missileRgbIn   (missileColor),
        .invaderRgbIn   (invaderColor),
        .vga            (vga));

    scoreCounter scoreInst (
        .clk            (clk),
        .rstN           (rstN),
        .objectReset    (objectReset),
        .killPulse      (killPulse),
        .hex0           (hex0),
        .hex1           (hex1),
        .hex2           (hex2));

endmodule

`default_nettype wire

// ==== dv/invadersTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module invadersTb;
    import videoPkg::*;
    import gamePkg::*;

    localparam int frameCycles = int'(hTotal) * int'(vTotal);
    localparam int maxFrames = 1200; // the win and loss rounds take about 410 frames each at most.
    localparam longint watchdogNs = longint'(maxFrames) * frameCycles * 4 + 2000;

    logic clk;
    logic rstN;
    logic startGame;
    logic pause;
    logic moveLeft;
    logic moveRight;
    logic fire;
    vgaT vga;
    segT hex0;
    segT hex1;
    segT hex2;
    logic gameWon;
    logic gameOver;

    int seed = 32'h57367470;
    pixelT cx;
    pixelT cy;
    pixelT d1x;
    pixelT d1y;
    pixelT d2x;
    pixelT d2y;
    logic d1v;
    logic d2v;
    logic idlePhase;
    logic winPhase;
    logic pauseHeld;
    logic restarting;
    logic expHSync;
    logic expVSync;
    logic d2Visible;
    logic inShipStart;
    logic inInvaderStart;
    int digitOnes;
    int digitTens;
    int digitHundreds;
    logic scoreValid;
    int scoreVal;
    int prevScore;
    logic prevWon;
    pixelT lastInvX = invaderStartX + rowW - 11'd1; // right edge of the row at the start.
    pixelT lastInvY = invaderStartY + invaderH - 11'd1;

    invadersTop dut0 (
        .clk        (clk),
        .rstN       (rstN),
        .startGame  (startGame),
        .pause      (pause),
        .moveLeft   (moveLeft),
        .moveRight  (moveRight),
        .fire       (fire),
        .vga        (vga),
        .hex0       (hex0),
        .hex1       (hex1),
        .hex2       (hex2),
        .gameWon    (gameWon),
        .gameOver   (gameOver));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(watchdogNs);
        $display("Watchdog timeout: the run did not finish in the expected time.");
        $display("Test FAILED");
        $fatal(1);
    end

    // ##################################################
    // reporting and reference functions
    // ##################################################
    task automatic reportMismatch(input string name, input int got, input int exp);
        $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic reportFailure(input string msg);
        $display("Failure at %0t ns: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    function automatic int segToDigit(input segT s);
        case (s) // segment a is bit 0 and a lit segment reads 0.
            7'b1000000: return 0;
            7'b1111001: return 1;
            7'b0100100: return 2;
            7'b0110000: return 3;
            7'b0011001: return 4;
            7'b0010010: return 5;
            7'b0000010: return 6;
            7'b1111000: return 7;
            7'b0000000: return 8;
            7'b0010000: return 9;
            default: return -1;
        endcase
    endfunction

    function automatic logic insideShipStart(input pixelT x, input pixelT y);
        return x >= shipStartX && x < shipStartX + shipW && y >= shipY && y < shipY + shipH;
    endfunction

    function automatic logic insideInvaderStart(input pixelT x, input pixelT y);
        logic hit;
        pixelT left;
        hit = 1'b0;
        for (int i = 0; i < numInvaders; i++) begin
            left = invaderStartX + pixelT'(i) * (invaderW + invaderGap);
            if (x >= left && x < left + invaderW && y >= invaderStartY
                    && y < invaderStartY + invaderH) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // ##################################################
    // raster model two cycles behind the scanner
    // ##################################################
    always @(posedge clk) begin
        if (!rstN) begin
            cx <= '0;
            cy <= '0;
            d1v <= 1'b0;
            d2v <= 1'b0;
            prevScore <= 0;
            prevWon <= 1'b0;
        end else begin
            if (cx == hTotal - 11'd1) begin
                cx <= '0;
                cy <= (cy == vTotal - 11'd1) ? '0 : cy + 11'd1;
            end else begin
                cx <= cx + 11'd1;
            end
            d1x <= cx;
            d1y <= cy;
            d1v <= 1'b1;
            d2x <= d1x;
            d2y <= d1y;
            d2v <= d1v;
            prevScore <= scoreVal;
            prevWon <= gameWon;
        end
    end

    always_comb begin
        expHSync = !(d2x >= hSyncStart && d2x < hSyncEnd);
        expVSync = !(d2y >= vSyncStart && d2y < vSyncEnd);
        d2Visible = d2x < hVisible && d2y < vVisible;
        inShipStart = insideShipStart(d2x, d2y);
        inInvaderStart = insideInvaderStart(d2x, d2y);
        digitOnes = segToDigit(hex0);
        digitTens = segToDigit(hex1);
        digitHundreds = segToDigit(hex2);
        scoreValid = digitOnes >= 0 && digitTens >= 0 && digitHundreds >= 0;
        scoreVal = scoreValid ? digitHundreds * 100 + digitTens * 10 + digitOnes : -1;
    end

    // the last invader pixel of a frame marks the bottom right of the rightmost invader.
    always @(negedge clk) begin
        if (d2v && vga.rgb == invaderRgb) begin
            lastInvX <= d2x;
            lastInvY <= d2y;
        end
    end

    // ##################################################
    // checks
    // ##################################################
    assert property (@(posedge clk) disable iff (!rstN) d2v |-> vga.hSync == expHSync)
        else reportMismatch("vga.hSync", $sampled(vga.hSync), $sampled(expHSync));
    assert property (@(posedge clk) disable iff (!rstN) d2v |-> vga.vSync == expVSync)
        else reportMismatch("vga.vSync", $sampled(vga.vSync), $sampled(expVSync));
    assert property (@(posedge clk) disable iff (!rstN) d2v && !d2Visible |-> vga.rgb == 8'h00)
        else reportMismatch("vga.rgb", $sampled(vga.rgb), 0);
    assert property (@(posedge clk) disable iff (!rstN)
        idlePhase && d2v && inShipStart |-> vga.rgb == shipRgb)
        else reportMismatch("vga.rgb", $sampled(vga.rgb), shipRgb);
    assert property (@(posedge clk) disable iff (!rstN)
        idlePhase && d2v && inInvaderStart |-> vga.rgb == invaderRgb)
        else reportMismatch("vga.rgb", $sampled(vga.rgb), invaderRgb);
    assert property (@(posedge clk) disable iff (!rstN)
        idlePhase && d2v && d2Visible && !inShipStart && !inInvaderStart
        |-> vga.rgb == backgroundRgb)
        else reportMismatch("vga.rgb", $sampled(vga.rgb), backgroundRgb);
    assert property (@(posedge clk) disable iff (!rstN) scoreValid)
        else reportFailure("a seven-segment output shows a pattern that is not a BCD digit.");
    assert property (@(posedge clk) disable iff (!rstN)
        scoreVal != prevScore
        |-> scoreVal == prevScore + killPoints || (restarting && scoreVal == 0))
        else reportMismatch("score", $sampled(scoreVal), $sampled(prevScore) + killPoints);
    assert property (@(posedge clk) disable iff (!rstN) winPhase |-> !gameOver)
        else reportFailure("gameOver rose while the game was being won.");
    assert property (@(posedge clk) disable iff (!rstN)
        gameWon && prevWon |-> scoreVal == prevScore)
        else reportMismatch("score", $sampled(scoreVal), $sampled(prevScore));
    assert property (@(posedge clk) disable iff (!rstN)
        pauseHeld |-> !gameWon && !gameOver && scoreVal == prevScore)
        else reportFailure("the game state or the score changed while paused.");

    // ##################################################
    // stimulus
    // ##################################################
    task automatic waitFrameStart();
        do begin
            @(negedge clk);
        end while (!(cx == '0 && cy == '0));
    endtask

    task automatic waitFrames(input int n);
        repeat (n) waitFrameStart();
    endtask

    task automatic pulseStart();
        @(negedge clk);
        startGame = 1'b1;
        restarting = 1'b1;
        idlePhase = 1'b0;
        @(negedge clk);
        startGame = 1'b0;
        repeat (2) @(negedge clk);
        restarting = 1'b0; // the score has been cleared by now.
    endtask

    task automatic playToWin();
        int shipEst;
        int prevX;
        int prevY;
        int xr;
        int flight;
        int lead;
        int col;
        int r;
        logic dirRight;
        shipEst = int'(shipStartX);
        prevX = int'(lastInvX);
        prevY = int'(lastInvY);
        dirRight = 1'b1;
        while (!(gameWon || gameOver)) begin
            waitFrameStart();
            xr = int'(lastInvX);
            if (int'(lastInvY) > prevY) begin
                dirRight = !dirRight; // the row dropped at a wall.
            end else if (xr == prevX + 1) begin
                dirRight = 1'b1;
            end else if (xr == prevX - 1) begin
                dirRight = 1'b0;
            end
            prevX = xr;
            prevY = int'(lastInvY);
            flight = (44 - int'(lastInvY)) / 2;
            lead = dirRight ? flight + 1 : -(flight + 1);
            col = shipEst + int'(shipW) / 2; // the missile takes the column before the move.
            fire = col >= xr - 4 + lead && col <= xr - 1 + lead;
            r = $random(seed) & 3;
            moveLeft = r == 0 && shipEst > 34;
            moveRight = r == 1 && shipEst < 38;
            shipEst = shipEst - int'(moveLeft) + int'(moveRight);
        end
        moveLeft = 1'b0;
        moveRight = 1'b0;
        fire = 1'b0;
    endtask

    initial begin
        rstN = 1'b0;
        startGame = 1'b0;
        pause = 1'b0;
        moveLeft = 1'b0;
        moveRight = 1'b0;
        fire = 1'b0;
        idlePhase = 1'b1;
        winPhase = 1'b0;
        pauseHeld = 1'b0;
        restarting = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        waitFrames(2);

        pulseStart(); // winning round.
        winPhase = 1'b1;
        playToWin();
        @(negedge clk);
        assert (gameWon) else reportFailure("the winning round did not end in a win.");
        assert (scoreVal == 40) else reportMismatch("score", scoreVal, 40);
        winPhase = 1'b0;
        waitFrames(2);

        pulseStart(); // losing round without a shot.
        repeat (3) @(negedge clk);
        assert (scoreVal == 0) else reportMismatch("score", scoreVal, 0);
        while (!(gameOver || gameWon)) @(negedge clk);
        assert (gameOver && !gameWon) else reportFailure("the round without shots was won.");
        waitFrames(2);

        pulseStart(); // pause during play.
        fire = 1'b1;
        waitFrames(5);
        pause = 1'b1;
        repeat (2) @(negedge clk);
        pauseHeld = 1'b1;
        waitFrames(20);
        pauseHeld = 1'b0;
        pause = 1'b0;
        waitFrames(3);
        fire = 1'b0;

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== invadersTop.f ====
logic/videoPkg.sv
logic/gamePkg.sv
logic/pixelScanner.sv
logic/gameController.sv
logic/playerShip.sv
logic/invaderRow.sv
logic/hitDetection.sv
logic/videoMixer.sv
logic/scoreCounter.sv
logic/invadersTop.sv
dv/invadersTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Builds and runs the invaders testbench with Verilator.
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module invadersTb \
    -f invadersTop.f -o simv 2>&1 | tee build.log || { echo "build failed"; exit 1; }
./obj_dir/simv 2>&1 | tee sim.log

! grep -q "Test FAILED" sim.log && grep -q "Test OK" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
